/* memPkg.sv */
// Memory system shared types
package memPkg;

  localparam int AddrWidth    = 32;
  localparam int DataWidth    = 32;
  localparam int WordOffset   = 2;
  localparam int Sets         = 16;
  localparam int Ways         = 2;
  localparam int IndexWidth   = $clog2(Sets);
  localparam int TagWidth     = AddrWidth - IndexWidth - WordOffset;
  localparam int MemWords     = 1024;
  localparam int MemIdxWidth  = $clog2(MemWords);
  localparam int WaitStates   = 2;
  localparam int WaitCntWidth = $clog2(WaitStates + 1);

  typedef logic [AddrWidth-1:0]     addrT;
  typedef logic [DataWidth-1:0]     dataT;
  typedef logic [IndexWidth-1:0]    indexT;
  typedef logic [TagWidth-1:0]      tagT;
  typedef logic [$clog2(Ways)-1:0]  wayIdxT;
  typedef logic [MemIdxWidth-1:0]   memIdxT;

  // Processor side
  typedef struct packed {
    logic write;
    addrT addr;
    dataT wdata;
  } cpuReqT;

  typedef struct packed {
    dataT rdata;
    logic hit;
  } cpuRespT;

  // Controller to ways
  typedef struct packed {
    indexT index;
    tagT   tag;
  } wayLookupT;

  typedef struct packed {
    logic [Ways-1:0] we;
    indexT           index;
    tagT             tag;
    dataT            data;
  } wayFillT;

  // Request held toward the bus memory until ready
  typedef struct packed {
    logic req;
    logic write;
    addrT addr;
    dataT wdata;
  } busReqT;

  typedef enum logic [2:0] {Idle, Lookup, BusRead, BusWrite, Respond} ctrlStateT;

endpackage

/* cacheWay.sv */
// Cache way storage
module cacheWay import memPkg::*;
(
  input  logic      clk,
  input  logic      rstN,
  input  wayLookupT lookup,
  input  wayFillT   fill,
  input  logic      invalidateAll,
  input  wayIdxT    wayId,
  output logic      hit,
  output dataT      rdata
);

  logic [Sets-1:0] validArr;
  tagT             tagArr [Sets];
  dataT            dataArr [Sets];
  logic            rdValid;
  tagT             rdTag;
  logic            wayWe;

  // Only this way's enable bit matters
  assign wayWe = fill.we[wayId];

  always_ff @(posedge clk)
  begin
    if (!rstN || invalidateAll)
      validArr <= '0;
    else if (wayWe)
      validArr[fill.index] <= 1'b1;
  end

  // Tag and data arrays, read every cycle at the lookup index
  always_ff @(posedge clk)
  begin
    if (wayWe)
    begin
      tagArr[fill.index]  <= fill.tag;
      dataArr[fill.index] <= fill.data;
    end
    rdTag <= tagArr[lookup.index];
    rdata <= dataArr[lookup.index];
  end

  // Invalidate also kills a read taken on the same edge
  always_ff @(posedge clk)
  begin
    if (!rstN || invalidateAll)
      rdValid <= 1'b0;
    else
      rdValid <= validArr[lookup.index];
  end

  // Compare against the tag the controller is still holding
  assign hit = rdValid && (rdTag == lookup.tag);

  // Controller only invalidates from Idle and only fills during bus states
  fillNotWithInvalidate: assert property (@(posedge clk) disable iff (!rstN)
    !((|fill.we) && invalidateAll));

endmodule

/* wayMerge.sv */
// Way hit merge and LRU tracking
module wayMerge import memPkg::*;
(
  input  logic            clk,
  input  logic            rstN,
  input  logic [Ways-1:0] hitVec,
  input  dataT            wayData [Ways],
  input  wayLookupT       lookup,
  input  logic            touch,
  input  wayIdxT          touchWay,
  output logic            anyHit,
  output dataT            hitData,
  output wayIdxT          hitWay,
  output wayIdxT          victim
);

  // One bit per set names the least recently used way
  logic [Sets-1:0] lruBits;

  assign anyHit = |hitVec;

  // Select the hitting way
  always_comb
  begin
    hitData = '0;
    hitWay  = '0;
    for (int w = 0; w < Ways; w++)
    begin
      if (hitVec[w])
      begin
        hitData = wayData[w];
        hitWay  = wayIdxT'(w);
      end
    end
  end

  assign victim = lruBits[lookup.index];

  // With two ways the LRU way is simply the other one
  always_ff @(posedge clk)
  begin
    if (!rstN)
      lruBits <= '0;
    else if (touch)
      lruBits[lookup.index] <= ~touchWay;
  end

  // Fills only go to a way that missed, so tags stay unique within a set
  oneWayHits: assert property (@(posedge clk) disable iff (!rstN)
    $onehot0(hitVec));

endmodule

/* cacheController.sv */
// Data cache controller
module cacheController import memPkg::*;
(
  input  logic      clk,
  input  logic      rstN,
  input  logic      cacheEnable,
  input  logic      invalidate,
  input  logic      reqValid,
  input  cpuReqT    req,
  output logic      busy,
  output logic      respValid,
  output cpuRespT   resp,
  output wayLookupT lookup,
  output wayFillT   fill,
  output logic      invalidateAll,
  input  logic      anyHit,
  input  dataT      hitData,
  input  wayIdxT    victim,
  input  wayIdxT    hitWay,
  output logic      touch,
  output wayIdxT    touchWay,
  output busReqT    bus,
  input  dataT      busRData,
  input  logic      busReady
);

  ctrlStateT state;
  ctrlStateT nextState;
  cpuReqT    reqQ;
  addrT      lookAddr;
  logic      accept;
  logic      readHit;
  logic      writeHit;

  assign accept        = (state == Idle) && reqValid;
  assign busy          = (state != Idle);
  assign invalidateAll = (state == Idle) && invalidate;

  // Index straight from the strobe so the arrays are read before Lookup
  assign lookAddr     = (state == Idle) ? req.addr : reqQ.addr;
  assign lookup.index = lookAddr[IndexWidth+WordOffset-1:WordOffset];
  assign lookup.tag   = lookAddr[AddrWidth-1:IndexWidth+WordOffset];

  assign readHit  = cacheEnable && anyHit && !reqQ.write;
  assign writeHit = cacheEnable && anyHit && reqQ.write;

  always_comb
  begin
    nextState = state;
    case (state)
      Idle:
        if (accept)
          nextState = Lookup;
      Lookup:
        if (reqQ.write)
          nextState = BusWrite;
        else if (readHit)
          nextState = Respond;
        else
          nextState = BusRead;
      BusRead,
      BusWrite:
        if (busReady)
          nextState = Respond;
      default:
        nextState = Idle;
    endcase
  end

  // Fill and LRU update
  always_comb
  begin
    fill.we    = '0;
    fill.index = lookup.index;
    fill.tag   = lookup.tag;
    fill.data  = busRData;
    touch      = 1'b0;
    touchWay   = hitWay;
    case (state)
      Lookup:
        touch = readHit;
      BusRead:
        if (busReady && cacheEnable)
        begin
          fill.we[victim] = 1'b1;
          touch           = 1'b1;
          touchWay        = victim;
        end
      BusWrite:
        // Write-through, so only a hit updates the cached copy
        if (busReady && writeHit)
        begin
          fill.we[hitWay] = 1'b1;
          fill.data       = reqQ.wdata;
          touch           = 1'b1;
        end
      default:
        touch = 1'b0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      state     <= Idle;
      respValid <= 1'b0;
      bus.req   <= 1'b0;
    end
    else
    begin
      state     <= nextState;
      respValid <= (nextState == Respond);
      if (accept)
        reqQ <= req;
      if (state == Lookup && nextState != Respond)
      begin
        bus.req   <= 1'b1;
        bus.write <= reqQ.write;
        bus.addr  <= reqQ.addr;
        bus.wdata <= reqQ.wdata;
      end
      else if (busReady)
        bus.req <= 1'b0;
      if (state == Lookup && readHit)
      begin
        resp.rdata <= hitData;
        resp.hit   <= 1'b1;
      end
      else if (state == BusRead && busReady)
      begin
        resp.rdata <= busRData;
        resp.hit   <= 1'b0;
      end
      else if (state == BusWrite && busReady)
      begin
        resp.rdata <= reqQ.wdata;
        resp.hit   <= writeHit;
      end
    end
  end

  noReqWhileBusy: assert property (@(posedge clk) disable iff (!rstN)
    reqValid |-> !busy);

  respInRespond: assert property (@(posedge clk) disable iff (!rstN)
    respValid |-> (state == Respond || state == Lookup));

  // Memory samples the request over several wait cycles
  busHeldUntilReady: assert property (@(posedge clk) disable iff (!rstN)
    bus.req && !busReady |=> bus.req && $stable(bus));

endmodule

/* ahbMemory.sv */
// Bus word memory with wait states
module ahbMemory import memPkg::*;
(
  input  logic   clk,
  input  logic   rstN,
  input  busReqT bus,
  output dataT   rdata,
  output logic   ready
);

  dataT                    mem [MemWords];
  logic [WaitCntWidth-1:0] waitCnt;
  memIdxT                  wordIdx;
  logic                    lastWait;
  logic                    access;

  // Addresses alias above the memory size
  assign wordIdx  = bus.addr[MemIdxWidth+WordOffset-1:WordOffset];
  assign lastWait = (waitCnt == WaitCntWidth'(WaitStates - 1));

  // The ready cycle itself is not counted
  assign access = bus.req && !ready && lastWait;

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      waitCnt <= '0;
      ready   <= 1'b0;
    end
    else
    begin
      ready <= 1'b0;
      if (bus.req && !ready)
      begin
        if (lastWait)
        begin
          waitCnt <= '0;
          ready   <= 1'b1;
        end
        else
        begin
          waitCnt <= waitCnt + WaitCntWidth'(1);
        end
      end
    end
  end

  // Storage and read register
  always_ff @(posedge clk)
  begin
    if (access)
    begin
      if (bus.write)
        mem[wordIdx] <= bus.wdata;
      else
        rdata <= mem[wordIdx];
    end
  end

endmodule

/* memSystem.sv */
// Cached data memory subsystem
module memSystem import memPkg::*;
(
  input  logic    clk,
  input  logic    rstN,
  input  logic    cacheEnable,
  input  logic    invalidate,
  input  logic    reqValid,
  input  cpuReqT  req,
  output logic    busy,
  output logic    respValid,
  output cpuRespT resp
);

  wayLookupT       lookup;
  wayFillT         fill;
  logic            invalidateAll;
  logic [Ways-1:0] hitVec;
  dataT            wayData [Ways];
  logic            anyHit;
  dataT            hitData;
  wayIdxT          victim;
  wayIdxT          hitWay;
  logic            touch;
  wayIdxT          touchWay;
  busReqT          bus;
  dataT            busRData;
  logic            busReady;

  cacheController uController (
    .clk          (clk          ),
    .rstN         (rstN         ),
    .cacheEnable  (cacheEnable  ),
    .invalidate   (invalidate   ),
    .reqValid     (reqValid     ),
    .req          (req          ),
    .busy         (busy         ),
    .respValid    (respValid    ),
    .resp         (resp         ),
    .lookup       (lookup       ),
    .fill         (fill         ),
    .invalidateAll(invalidateAll),
    .anyHit       (anyHit       ),
    .hitData      (hitData      ),
    .victim       (victim       ),
    .hitWay       (hitWay       ),
    .touch        (touch        ),
    .touchWay     (touchWay     ),
    .bus          (bus          ),
    .busRData     (busRData     ),
    .busReady     (busReady     )
  );

  // Identical ways, each picks its own fill enable by wayId
  for (genvar w = 0; w < Ways; w++)
  begin : gWay
    cacheWay uWay (
      .clk          (clk          ),
      .rstN         (rstN         ),
      .lookup       (lookup       ),
      .fill         (fill         ),
      .invalidateAll(invalidateAll),
      .wayId        (wayIdxT'(w)  ),
      .hit          (hitVec[w]    ),
      .rdata        (wayData[w]   )
    );
  end

  wayMerge uMerge (
    .clk     (clk     ),
    .rstN    (rstN    ),
    .hitVec  (hitVec  ),
    .wayData (wayData ),
    .lookup  (lookup  ),
    .touch   (touch   ),
    .touchWay(touchWay),
    .anyHit  (anyHit  ),
    .hitData (hitData ),
    .hitWay  (hitWay  ),
    .victim  (victim  )
  );

  ahbMemory uMemory (
    .clk  (clk     ),
    .rstN (rstN    ),
    .bus  (bus     ),
    .rdata(busRData),
    .ready(busReady)
  );

endmodule

/* memSystemTests.svh */
// Directed cache tests

  task automatic fillThenHit();
    int   startErrors;
    bit   hitSeen;
    int   cycles;
    addrT addrA;
    startErrors = errorCount;
    addrA       = 32'h0000_0104;
    strobeInvalidate();
    issueRequest(1'b1, addrA, 32'hCAFE_0001, hitSeen, cycles);
    issueRequest(1'b0, addrA, '0, hitSeen, cycles);
    checkFlag("resp.hit", 1'b0, hitSeen);
    issueRequest(1'b0, addrA, '0, hitSeen, cycles);
    checkFlag("resp.hit", 1'b1, hitSeen);
    // Hit answers two cycles after the strobe
    checkWord("respValid latency", 32'd2, cycles);
    finishTest("fill then hit", startErrors);
  endtask

  task automatic lruReplacement();
    int   startErrors;
    bit   hitSeen;
    int   cycles;
    addrT addrA;
    addrT addrB;
    addrT addrC;
    startErrors = errorCount;
    // Three tags in set 3
    addrA = 32'h0000_040C;
    addrB = 32'h0000_044C;
    addrC = 32'h0000_048C;
    strobeInvalidate();
    issueRequest(1'b1, addrA, 32'hA0A0_0001, hitSeen, cycles);
    issueRequest(1'b1, addrB, 32'hB0B0_0002, hitSeen, cycles);
    issueRequest(1'b1, addrC, 32'hC0C0_0003, hitSeen, cycles);
    issueRequest(1'b0, addrA, '0, hitSeen, cycles);
    issueRequest(1'b0, addrB, '0, hitSeen, cycles);
    issueRequest(1'b0, addrA, '0, hitSeen, cycles);
    // B is now least recently used and C evicts it
    issueRequest(1'b0, addrC, '0, hitSeen, cycles);
    issueRequest(1'b0, addrA, '0, hitSeen, cycles);
    checkFlag("resp.hit", 1'b1, hitSeen);
    issueRequest(1'b0, addrB, '0, hitSeen, cycles);
    checkFlag("resp.hit", 1'b0, hitSeen);
    finishTest("LRU replacement", startErrors);
  endtask

  task automatic writeThrough();
    int   startErrors;
    bit   hitSeen;
    int   cycles;
    addrT addrX;
    addrT addrY;
    startErrors = errorCount;
    addrX       = 32'h0000_0208;
    addrY       = 32'h0000_0248;
    strobeInvalidate();
    issueRequest(1'b1, addrX, 32'h1111_0000, hitSeen, cycles);
    issueRequest(1'b0, addrX, '0, hitSeen, cycles);
    issueRequest(1'b1, addrX, 32'h2222_0000, hitSeen, cycles);
    checkFlag("resp.hit", 1'b1, hitSeen);
    issueRequest(1'b0, addrX, '0, hitSeen, cycles);
    checkFlag("resp.hit", 1'b1, hitSeen);
    // No write allocate
    issueRequest(1'b1, addrY, 32'h3333_0000, hitSeen, cycles);
    issueRequest(1'b0, addrY, '0, hitSeen, cycles);
    checkFlag("resp.hit", 1'b0, hitSeen);
    finishTest("write-through", startErrors);
  endtask

  task automatic disableCache();
    int   startErrors;
    bit   hitSeen;
    int   cycles;
    addrT addrD;
    startErrors = errorCount;
    addrD       = 32'h0000_0314;
    strobeInvalidate();
    issueRequest(1'b1, addrD, 32'hD15A_B1ED, hitSeen, cycles);
    cacheEnable = 1'b0;
    for (int i = 0; i < 3; i++)
    begin
      issueRequest(1'b0, addrD, '0, hitSeen, cycles);
      checkFlag("resp.hit", 1'b0, hitSeen);
    end
    cacheEnable = 1'b1;
    // Disabled reads filled nothing
    issueRequest(1'b0, addrD, '0, hitSeen, cycles);
    checkFlag("resp.hit", 1'b0, hitSeen);
    finishTest("cache disable", startErrors);
  endtask

  task automatic invalidateCache();
    int   startErrors;
    bit   hitSeen;
    int   cycles;
    addrT addrE;
    startErrors = errorCount;
    addrE       = 32'h0000_07F8;
    issueRequest(1'b1, addrE, 32'hE0E0_5555, hitSeen, cycles);
    issueRequest(1'b0, addrE, '0, hitSeen, cycles);
    issueRequest(1'b0, addrE, '0, hitSeen, cycles);
    checkFlag("resp.hit", 1'b1, hitSeen);
    strobeInvalidate();
    issueRequest(1'b0, addrE, '0, hitSeen, cycles);
    checkFlag("resp.hit", 1'b0, hitSeen);
    finishTest("invalidate", startErrors);
  endtask

  task automatic randomMix();
    int          startErrors;
    bit          hitSeen;
    int          cycles;
    int unsigned tagSel;
    int unsigned setSel;
    bit          doWrite;
    dataT        wdata;
    addrT        addr;
    startErrors = errorCount;
    for (int i = 0; i < 60; i++)
    begin
      tagSel = $urandom % 8;
      setSel = $urandom % 4;
      addr   = {tagT'(tagSel + 32), indexT'(setSel * 3), 2'b00};
      // Never read a word that was not written
      doWrite = ($urandom % 3 == 0) || !refWritten[memIndex(addr)];
      wdata   = $urandom;
      issueRequest(doWrite, addr, wdata, hitSeen, cycles);
    end
    finishTest("random mix", startErrors);
  endtask

/* memSystemTb.sv */
// Memory system testbench
module memSystemTb import memPkg::*;
();

  localparam int TimeoutCycles = 40;

  logic    clk;
  logic    rstN;
  logic    cacheEnable;
  logic    invalidate;
  logic    reqValid;
  cpuReqT  req;
  logic    busy;
  logic    respValid;
  cpuRespT resp;

  // Reference memory, aliased like the bus memory
  dataT refMem [MemWords];
  bit   refWritten [MemWords];

  // Reference cache state per set
  bit  modelValid [Sets][Ways];
  tagT modelTag [Sets][Ways];
  bit  modelLru [Sets];

  int errorCount;
  int checkCount;
  int testCount;

  memSystem u_memSystem (
    .clk        (clk        ),
    .rstN       (rstN       ),
    .cacheEnable(cacheEnable),
    .invalidate (invalidate ),
    .reqValid   (reqValid   ),
    .req        (req        ),
    .busy       (busy       ),
    .respValid  (respValid  ),
    .resp       (resp       )
  );

  always #4 clk = ~clk;

  // Word index into memory, bits 11 to 2
  function automatic int memIndex(input addrT addr);
    return int'(addr[11:2]);
  endfunction

  task automatic checkWord(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    checkCount++;
    assert (actual === expected)
    else
    begin
      errorCount++;
      $display("[FAIL] %0t %s: expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic checkFlag(input string name, input logic expected, input logic actual);
    checkCount++;
    assert (actual === expected)
    else
    begin
      errorCount++;
      $display("[FAIL] %0t %s: expected %b, got %b", $time, name, expected, actual);
    end
  endtask

  // Predict the hit flag, then apply the hit, fill and LRU rules
  task automatic modelAccess(input bit write, input addrT addr, output bit expHit);
    int  setIdx;
    tagT tag;
    int  hitWay;
    int  v;
    setIdx = int'(addr[5:2]);
    tag    = addr[31:6];
    hitWay = -1;
    for (int w = 0; w < Ways; w++)
    begin
      if (modelValid[setIdx][w] && modelTag[setIdx][w] == tag)
        hitWay = w;
    end
    expHit = cacheEnable && (hitWay >= 0);
    if (cacheEnable)
    begin
      if (hitWay >= 0)
        modelLru[setIdx] = (hitWay == 0);
      else if (!write)
      begin
        // Read miss fills the LRU way, write miss allocates nothing
        v = modelLru[setIdx];
        modelValid[setIdx][v] = 1'b1;
        modelTag[setIdx][v]   = tag;
        modelLru[setIdx]      = (v == 0);
      end
    end
  endtask

  task automatic waitIdle(output bit idle);
    int waitCount;
    waitCount = 0;
    while (busy && waitCount < TimeoutCycles)
    begin
      @(posedge clk);
      #1;
      waitCount++;
    end
    idle = !busy;
    if (!idle)
    begin
      errorCount++;
      $display("Timeout at %0t: busy never dropped before the next request", $time);
    end
  endtask

  // One request strobe, then wait for respValid and check the response
  task automatic issueRequest(input bit write, input addrT addr, input dataT wdata,
                              output bit hitSeen, output int cycles);
    bit   idle;
    bit   expHit;
    dataT expData;
    int   idx;
    hitSeen = 1'b0;
    cycles  = 0;
    idx     = memIndex(addr);
    waitIdle(idle);
    if (idle)
    begin
      modelAccess(write, addr, expHit);
      if (write)
      begin
        refMem[idx]     = wdata;
        refWritten[idx] = 1'b1;
      end
      expData   = refMem[idx];
      req.write = write;
      req.addr  = addr;
      req.wdata = wdata;
      reqValid  = 1'b1;
      @(posedge clk);
      #1;
      reqValid = 1'b0;
      cycles   = 1;
      // Busy from the cycle after acceptance
      checkFlag("busy", 1'b1, busy);
      while (!respValid && cycles < TimeoutCycles)
      begin
        @(posedge clk);
        #1;
        cycles++;
      end
      if (!respValid)
      begin
        errorCount++;
        $display("Timeout at %0t: no respValid for address %h", $time, addr);
      end
      else
      begin
        hitSeen = resp.hit;
        checkWord("resp.rdata", expData, resp.rdata);
        checkFlag("resp.hit", expHit, resp.hit);
        checkFlag("busy", 1'b1, busy);
        // One-cycle response, then back to idle
        @(posedge clk);
        #1;
        checkFlag("respValid", 1'b0, respValid);
        checkFlag("busy", 1'b0, busy);
      end
    end
  endtask

  task automatic strobeInvalidate();
    bit idle;
    waitIdle(idle);
    if (idle)
    begin
      invalidate = 1'b1;
      @(posedge clk);
      #1;
      invalidate = 1'b0;
      for (int s = 0; s < Sets; s++)
      begin
        for (int w = 0; w < Ways; w++)
          modelValid[s][w] = 1'b0;
      end
    end
  endtask

  task automatic finishTest(input string name, input int startErrors);
    testCount++;
    $display("Test %0d, %s: finished with %0d errors", testCount, name,
             errorCount - startErrors);
  endtask

  `include "memSystemTests.svh"

  initial
  begin
    void'($urandom(65));
    clk         = 1'b0;
    rstN        = 1'b0;
    cacheEnable = 1'b1;
    invalidate  = 1'b0;
    reqValid    = 1'b0;
    req         = '0;
    errorCount  = 0;
    checkCount  = 0;
    testCount   = 0;
    repeat (10) @(posedge clk);
    #1;
    rstN = 1'b1;
    fillThenHit();
    lruReplacement();
    writeThrough();
    disableCache();
    invalidateCache();
    randomMix();
    $display("Tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, errorCount);
    if (errorCount == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* project.f */
+incdir+.
memPkg.sv
cacheWay.sv
wayMerge.sv
cacheController.sv
ahbMemory.sv
memSystem.sv
memSystemTb.sv
